/* dv/ps2_stim.txt */
# op byte parity_bad stop_bad frame_err  (op: F frame, R read all, W start bit then stall)
# byte is hex, other columns are 0 or 1
F 1C 0 0 0
F 32 0 0 0
F 21 0 0 0
F 23 0 0 0
F 24 0 0 0
F 2B 0 0 0
F 34 0 0 0
F 33 0 0 0
F 43 0 0 0
F 3B 0 0 0
R 00 0 0 0
F F0 0 0 0
F 1C 0 0 0
F E0 0 0 0
F 75 0 0 0
F E0 0 0 0
F F0 0 0 0
F 6B 0 0 0
F 1C 1 0 1
F 2D 0 1 1
F E0 0 0 0
F F0 0 0 0
F 4D 1 0 1
F 29 0 0 0
R 00 0 0 0
F 15 0 0 0
F 1D 0 0 0
F 24 0 0 0
F 2D 0 0 0
F 2C 0 0 0
F 35 0 0 0
F 3C 0 0 0
F 43 0 0 0
F 44 0 0 0
R 00 0 0 0
W 00 0 0 1
F 5A 0 0 0
R 00 0 0 0

/* sources.f */
hdl/ps2_pkg.sv
hdl/ps2_line_sync.sv
hdl/ps2_frame_rx.sv
hdl/ps2_scan_decoder.sv
hdl/ps2_event_fifo.sv
hdl/ps2_keyboard_rx.sv
dv/ps2_keyboard_rx_assertions.sv
dv/ps2_keyboard_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the PS/2 receiver testbench with Verilator
set -u
cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -f sources.f \
  --top-module ps2_keyboard_rx_tb -o ps2_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ps2_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* dv/ps2_keyboard_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx_tb import ps2_pkg::*; ();

  // PS/2 half period in system cycles
  localparam int HALF_CYC = 40;

  logic       clk_50_i;
  logic       rst_i;
  logic       ps2_clk_i;
  logic       ps2_dat_i;
  logic       evt_rd_i;
  logic       evt_valid_o;
  scan_code_t evt_code_o;
  logic       evt_release_o;
  logic       evt_extended_o;
  logic       frame_err_o;
  logic       overflow_o;

  int       seed = 32'h1be4;
  int       byte_cnt;
  int       err_cnt;
  int       ovf_cnt;
  logic     mdl_ext;
  logic     mdl_rel;
  logic     exp_ovf;
  ps2_evt_t exp_q[$];

  ps2_keyboard_rx dut (
    .clk_50_i       (clk_50_i),
    .rst_i          (rst_i),
    .ps2_clk_i      (ps2_clk_i),
    .ps2_dat_i      (ps2_dat_i),
    .evt_rd_i       (evt_rd_i),
    .evt_valid_o    (evt_valid_o),
    .evt_code_o     (evt_code_o),
    .evt_release_o  (evt_release_o),
    .evt_extended_o (evt_extended_o),
    .frame_err_o    (frame_err_o),
    .overflow_o     (overflow_o)
  );

  initial begin
    clk_50_i = 1'b0;
    forever #10 clk_50_i = ~clk_50_i;
  end

  // Pulse counters, read only at falling edges
  always @(posedge clk_50_i or posedge rst_i) begin
    if (rst_i) begin
      byte_cnt <= 0;
      err_cnt  <= 0;
      ovf_cnt  <= 0;
    end else begin
      if (dut.byte_valid) begin
        byte_cnt <= byte_cnt + 1;
      end
      if (frame_err_o) begin
        err_cnt <= err_cnt + 1;
      end
      if (overflow_o) begin
        ovf_cnt <= ovf_cnt + 1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_code(input string name, input scan_code_t exp, input scan_code_t act);
    if (act !== exp) begin
      fail_now($sformatf("error at %0t ns: %s expected %h, got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("error at %0t ns: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task automatic expect_pulses(input string name, input logic exp, input int got);
    if (got > 1) begin
      fail_now({name, " pulsed more than once for a single stimulus line"});
    end
    check_flag(name, exp, got == 1);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // PS/2 device side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk_50_i);
  endtask

  // Data changes while the clock is high
  task automatic send_bit(input logic b);
    int jit;
    jit = $random(seed) & 3;
    ps2_dat_i <= b;
    idle_cycles(HALF_CYC + jit);
    ps2_clk_i <= 1'b0;
    idle_cycles(HALF_CYC);
    ps2_clk_i <= 1'b1;
  endtask

  task automatic send_frame(input scan_code_t b, input logic pbad, input logic sbad);
    logic par;
    par = (~^b) ^ pbad;
    send_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      send_bit(b[i]);
    end
    send_bit(par);
    send_bit(!sbad);
    ps2_dat_i <= 1'b1;
    idle_cycles(HALF_CYC);
  endtask

  // Prefix model of scan code set 2
  task automatic model_byte(input scan_code_t b, input logic bad);
    if (bad) begin
      mdl_ext = 1'b0;
      mdl_rel = 1'b0;
    end else if (b == CODE_EXTENDED) begin
      mdl_ext = 1'b1;
    end else if (b == CODE_RELEASE) begin
      mdl_rel = 1'b1;
    end else begin
      if (exp_q.size() < FIFO_DEPTH) begin
        exp_q.push_back({mdl_ext, mdl_rel, b});
      end else begin
        exp_ovf = 1'b1;
      end
      mdl_ext = 1'b0;
      mdl_rel = 1'b0;
    end
  endtask

  // Byte or error strobe, then room for the push into the queue
  task automatic wait_outcome(input int base, input int limit, input string what);
    int n;
    n = 0;
    while (byte_cnt + err_cnt == base) begin
      @(negedge clk_50_i);
      n++;
      if (n > limit) begin
        fail_now({"timeout waiting for ", what});
      end
    end
    idle_cycles(4);
    @(negedge clk_50_i);
  endtask

  task automatic read_all();
    ps2_evt_t e;
    int       n;
    while (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      n = 0;
      @(negedge clk_50_i);
      while (!evt_valid_o) begin
        n++;
        if (n > 100) begin
          fail_now("timeout waiting for evt_valid_o while events are still expected");
        end
        @(negedge clk_50_i);
      end
      check_code("evt_code_o", e[7:0], evt_code_o);
      check_flag("evt_release_o", e[8], evt_release_o);
      check_flag("evt_extended_o", e[9], evt_extended_o);
      @(posedge clk_50_i);
      evt_rd_i <= 1'b1;
      @(posedge clk_50_i);
      evt_rd_i <= 1'b0;
    end
    @(negedge clk_50_i);
    check_flag("evt_valid_o", 1'b0, evt_valid_o);
  endtask

  task automatic run_line(input logic [7:0] op, input scan_code_t b, input logic pbad,
                          input logic sbad, input logic exp_err);
    int base_err;
    int base_ovf;
    int base_sum;
    base_err = err_cnt;
    base_ovf = ovf_cnt;
    base_sum = byte_cnt + err_cnt;
    exp_ovf  = 1'b0;
    @(posedge clk_50_i);
    case (op)
      "F": begin
        model_byte(b, pbad || sbad);
        send_frame(b, pbad, sbad);
        wait_outcome(base_sum, 100, "end of frame");
      end
      "W": begin
        // Lone start bit, the watchdog ends the frame
        model_byte(b, 1'b1);
        send_bit(1'b0);
        ps2_dat_i <= 1'b1;
        wait_outcome(base_sum, FRAME_TIMEOUT_CYC + 200, "watchdog frame error");
      end
      "R": begin
        read_all();
      end
      default: begin
        fail_now("unknown opcode in dv/ps2_stim.txt");
      end
    endcase
    expect_pulses("frame_err_o", exp_err, err_cnt - base_err);
    expect_pulses("overflow_o", exp_ovf, ovf_cnt - base_ovf);
  endtask

  initial begin
    int          fd;
    int          rc;
    int          ch;
    logic [7:0]  op;
    scan_code_t  b;
    logic        pbad;
    logic        sbad;
    logic        nerr;
    rst_i     = 1'b1;
    ps2_clk_i = 1'b1;
    ps2_dat_i = 1'b1;
    evt_rd_i  = 1'b0;
    mdl_ext   = 1'b0;
    mdl_rel   = 1'b0;
    exp_ovf   = 1'b0;
    repeat (10) @(posedge clk_50_i);
    rst_i <= 1'b0;
    @(negedge clk_50_i);
    check_flag("evt_valid_o", 1'b0, evt_valid_o);
    check_flag("frame_err_o", 1'b0, frame_err_o);
    check_flag("overflow_o", 1'b0, overflow_o);

    fd = $fopen("dv/ps2_stim.txt", "r");
    if (fd == 0) begin
      fail_now("could not open dv/ps2_stim.txt");
    end
    while ($fscanf(fd, " %c", op) == 1) begin
      if (op == "#") begin
        ch = 0;
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        rc = $fscanf(fd, "%h %d %d %d", b, pbad, sbad, nerr);
        if (rc != 4) begin
          fail_now("malformed line in dv/ps2_stim.txt");
        end
        run_line(op, b, pbad, sbad, nerr);
      end
    end
    $fclose(fd);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/ps2_keyboard_rx_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx_assertions import ps2_pkg::*; (
  input logic             clk_50_i,
  input logic             rst_i,
  input logic             byte_valid_i,
  input logic             frame_err_i,
  input logic             overflow_i,
  input logic             evt_valid_i,
  input logic [FIFO_AW:0] fifo_count_i
);

  a_byte_err_excl: assert property (@(posedge clk_50_i) disable iff (rst_i)
    !(byte_valid_i && frame_err_i))
    else $error("byte_valid and frame_err high in the same cycle");

  // Drop only happens on a full queue
  a_overflow_full: assert property (@(posedge clk_50_i) disable iff (rst_i)
    overflow_i |-> (fifo_count_i == (FIFO_AW+1)'(FIFO_DEPTH)))
    else $error("overflow_o while the queue is not full");

  a_reset_empty: assert property (@(posedge clk_50_i)
    $fell(rst_i) |-> !evt_valid_i)
    else $error("evt_valid_o high right after reset");

endmodule

bind ps2_keyboard_rx ps2_keyboard_rx_assertions u_assertions (
  .clk_50_i      (clk_50_i),
  .rst_i         (rst_i),
  .byte_valid_i  (byte_valid),
  .frame_err_i   (frame_err),
  .overflow_i    (overflow_o),
  .evt_valid_i   (evt_valid_o),
  .fifo_count_i  (u_event_fifo.count_q)
);

`default_nettype wire

/* hdl/ps2_keyboard_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_keyboard_rx import ps2_pkg::*; (
  input  logic       clk_50_i,
  input  logic       rst_i,

  input  logic       ps2_clk_i,
  input  logic       ps2_dat_i,

  input  logic       evt_rd_i,
  output logic       evt_valid_o,
  output scan_code_t evt_code_o,
  output logic       evt_release_o,
  output logic       evt_extended_o,

  output logic       frame_err_o,
  output logic       overflow_o
);

  logic       ps2_fall;
  logic       ps2_dat_s;
  logic       byte_valid;
  scan_code_t byte_data;
  logic       frame_err;
  logic       evt_push;
  ps2_evt_t   evt_data;
  ps2_evt_t   evt_head;

  ps2_line_sync u_line_sync (
    .clk_50_i   (clk_50_i),
    .rst_i      (rst_i),
    .ps2_clk_i  (ps2_clk_i),
    .ps2_dat_i  (ps2_dat_i),
    .ps2_fall_o (ps2_fall),
    .ps2_dat_o  (ps2_dat_s)
  );

  ps2_frame_rx u_frame_rx (
    .clk_50_i     (clk_50_i),
    .rst_i        (rst_i),
    .ps2_fall_i   (ps2_fall),
    .ps2_dat_i    (ps2_dat_s),
    .byte_valid_o (byte_valid),
    .byte_data_o  (byte_data),
    .frame_err_o  (frame_err)
  );

  ps2_scan_decoder u_scan_decoder (
    .clk_50_i     (clk_50_i),
    .rst_i        (rst_i),
    .byte_valid_i (byte_valid),
    .byte_data_i  (byte_data),
    .frame_err_i  (frame_err),
    .evt_push_o   (evt_push),
    .evt_data_o   (evt_data)
  );

  ps2_event_fifo u_event_fifo (
    .clk_50_i    (clk_50_i),
    .rst_i       (rst_i),
    .push_i      (evt_push),
    .push_data_i (evt_data),
    .rd_i        (evt_rd_i),
    .valid_o     (evt_valid_o),
    .head_o      (evt_head),
    .overflow_o  (overflow_o)
  );

  // Head event fields
  assign evt_extended_o = evt_head[9];
  assign evt_release_o  = evt_head[8];
  assign evt_code_o     = evt_head[7:0];

  assign frame_err_o = frame_err;

endmodule

`default_nettype wire

/* hdl/ps2_event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_event_fifo import ps2_pkg::*; (
  input  logic     clk_50_i,
  input  logic     rst_i,

  input  logic     push_i,
  input  ps2_evt_t push_data_i,

  input  logic     rd_i,
  output logic     valid_o,
  output ps2_evt_t head_o,
  output logic     overflow_o
);

  ps2_evt_t           mem_q [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q;
  logic [FIFO_AW-1:0] rd_ptr_q;
  logic [FIFO_AW:0]   count_q;
  logic               full;
  logic               do_pop;
  logic               do_push;

  assign full    = (count_q == (FIFO_AW+1)'(FIFO_DEPTH));
  assign do_pop  = rd_i && valid_o;
  // A pop frees the slot in the same cycle
  assign do_push = push_i && (!full || do_pop);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pointers and fill level
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_50_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      overflow_o <= push_i && !do_push;
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_50_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Show-ahead head
  assign valid_o = (count_q != '0);
  assign head_o  = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

/* hdl/ps2_scan_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_scan_decoder import ps2_pkg::*; (
  input  logic       clk_50_i,
  input  logic       rst_i,

  input  logic       byte_valid_i,
  input  scan_code_t byte_data_i,
  input  logic       frame_err_i,

  output logic       evt_push_o,
  output ps2_evt_t   evt_data_o
);

  logic ext_q;
  logic rel_q;
  logic is_prefix;

  assign is_prefix = (byte_data_i == CODE_EXTENDED) || (byte_data_i == CODE_RELEASE);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Prefix flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_50_i or posedge rst_i) begin
    if (rst_i) begin
      ext_q      <= 1'b0;
      rel_q      <= 1'b0;
      evt_push_o <= 1'b0;
    end else begin
      evt_push_o <= 1'b0;
      if (frame_err_i) begin
        // Lost byte may have been the code, drop the pending prefix
        ext_q <= 1'b0;
        rel_q <= 1'b0;
      end else if (byte_valid_i) begin
        if (byte_data_i == CODE_EXTENDED) begin
          ext_q <= 1'b1;
        end else if (byte_data_i == CODE_RELEASE) begin
          rel_q <= 1'b1;
        end else begin
          ext_q      <= 1'b0;
          rel_q      <= 1'b0;
          evt_push_o <= 1'b1;
        end
      end
    end
  end

  // Event payload
  always_ff @(posedge clk_50_i) begin
    if (byte_valid_i && !is_prefix) begin
      evt_data_o <= {ext_q, rel_q, byte_data_i};
    end
  end

endmodule

`default_nettype wire

/* hdl/ps2_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_frame_rx import ps2_pkg::*; (
  input  logic       clk_50_i,
  input  logic       rst_i,

  input  logic       ps2_fall_i,
  input  logic       ps2_dat_i,

  output logic       byte_valid_o,
  output scan_code_t byte_data_o,
  output logic       frame_err_o
);

  localparam logic [TIMEOUT_W-1:0] TIMEOUT_LAST = TIMEOUT_W'(FRAME_TIMEOUT_CYC - 1);

  frame_state_t         state_q;
  logic [2:0]           bit_cnt_q;
  logic [TIMEOUT_W-1:0] timeout_q;
  scan_code_t           shift_q;
  logic                 parity_q;
  logic                 timeout_hit;
  logic                 frame_ok;

  assign timeout_hit = (state_q != FRAME_IDLE) && (timeout_q == TIMEOUT_LAST);

  // Odd parity over data plus parity bit, stop bit high
  assign frame_ok = (^{parity_q, shift_q}) && ps2_dat_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk_50_i or posedge rst_i) begin
    if (rst_i) begin
      state_q      <= FRAME_IDLE;
      bit_cnt_q    <= '0;
      byte_valid_o <= 1'b0;
      frame_err_o  <= 1'b0;
    end else begin
      byte_valid_o <= 1'b0;
      frame_err_o  <= 1'b0;
      if (ps2_fall_i) begin
        case (state_q)
          FRAME_IDLE: begin
            // High start bit is noise
            if (!ps2_dat_i) begin
              state_q   <= FRAME_DATA;
              bit_cnt_q <= '0;
            end
          end
          FRAME_DATA: begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= FRAME_PARITY;
            end
          end
          FRAME_PARITY: begin
            state_q <= FRAME_STOP;
          end
          FRAME_STOP: begin
            state_q      <= FRAME_IDLE;
            byte_valid_o <= frame_ok;
            frame_err_o  <= !frame_ok;
          end
          default: begin
            state_q <= FRAME_IDLE;
          end
        endcase
      end else if (timeout_hit) begin
        state_q     <= FRAME_IDLE;
        frame_err_o <= 1'b1;
      end
    end
  end

  // Watchdog restarts at every strobe
  always_ff @(posedge clk_50_i or posedge rst_i) begin
    if (rst_i) begin
      timeout_q <= '0;
    end else if (ps2_fall_i || timeout_hit || (state_q == FRAME_IDLE)) begin
      timeout_q <= '0;
    end else begin
      timeout_q <= timeout_q + 1'b1;
    end
  end

  // LSB arrives first
  always_ff @(posedge clk_50_i) begin
    if (ps2_fall_i && (state_q == FRAME_DATA)) begin
      shift_q <= {ps2_dat_i, shift_q[7:1]};
    end
    if (ps2_fall_i && (state_q == FRAME_PARITY)) begin
      parity_q <= ps2_dat_i;
    end
  end

  assign byte_data_o = shift_q;

endmodule

`default_nettype wire

/* hdl/ps2_line_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_line_sync import ps2_pkg::*; (
  input  logic clk_50_i,
  input  logic rst_i,

  input  logic ps2_clk_i,
  input  logic ps2_dat_i,
  output logic ps2_fall_o,
  output logic ps2_dat_o
);

  logic [1:0]              clk_sync_q;
  logic [1:0]              dat_sync_q;
  logic [EDGE_HISTORY-1:0] clk_hist_q;

  // Both lines idle high
  always_ff @(posedge clk_50_i or posedge rst_i) begin
    if (rst_i) begin
      clk_sync_q <= '1;
      dat_sync_q <= '1;
    end else begin
      clk_sync_q <= {clk_sync_q[0], ps2_clk_i};
      dat_sync_q <= {dat_sync_q[0], ps2_dat_i};
    end
  end

  // Newest sample enters at the top
  always_ff @(posedge clk_50_i or posedge rst_i) begin
    if (rst_i) begin
      clk_hist_q <= '1;
    end else begin
      clk_hist_q <= {clk_sync_q[1], clk_hist_q[EDGE_HISTORY-1:1]};
    end
  end

  // Oldest half high, newest half low
  assign ps2_fall_o = (&clk_hist_q[EDGE_HALF-1:0]) &&
                      !(|clk_hist_q[EDGE_HISTORY-1:EDGE_HALF]);
  assign ps2_dat_o  = dat_sync_q[1];

endmodule

`default_nettype wire

/* hdl/ps2_pkg.sv */
`default_nettype none

package ps2_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scan code set 2 prefixes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [7:0] CODE_EXTENDED = 8'hE0;
  localparam logic [7:0] CODE_RELEASE  = 8'hF0;

  // Clock line filter, half of the history must be high, half low
  localparam int EDGE_HISTORY = 10;
  localparam int EDGE_HALF    = EDGE_HISTORY / 2;

  // Stalled frame watchdog, in system cycles
  localparam int FRAME_TIMEOUT_CYC = 4096;
  localparam int TIMEOUT_W         = $clog2(FRAME_TIMEOUT_CYC);

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = 3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [7:0] scan_code_t;

  // Bit 9 extended, bit 8 release, bits 7:0 code
  typedef logic [9:0] ps2_evt_t;

  typedef enum logic [1:0] {
    FRAME_IDLE   = 2'd0,
    FRAME_DATA   = 2'd1,
    FRAME_PARITY = 2'd2,
    FRAME_STOP   = 2'd3
  } frame_state_t;

endpackage

`default_nettype wire
